// File: hdl/rv_core_pkg.sv
// rv32i subset core shared definitions
// widths, major opcodes, instruction classes and ALU operations

`default_nettype none

package rv_core_pkg;

    // --------------------
    // widths
    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int MEM_ADDR_BITS = 10;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [31:0]              pc_t;

    // --------------------
    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // anything outside the subset decodes to CLS_HALT
    typedef enum logic [2:0] {
        CLS_ALU_IMM, CLS_ALU_REG, CLS_LUI, CLS_JAL,
        CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_HALT
    } instr_class_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/rv_fetch.sv
// instruction fetch
// holds the program counter and the instruction register;
// the PC loads the start address, steps by 4 or takes a redirect

`default_nettype none
`timescale 1ns/1ns

module rv_fetch (
    input  wire                 clk,
    input  wire                 rst_n_i,

    input  wire                 fetch_init_i,
    input  wire rv_core_pkg::pc_t   start_addr_i,

    input  wire                 fetch_next_i,
    input  wire                 redirect_i,
    input  wire rv_core_pkg::pc_t   target_i,

    input  wire                 ir_load_i,
    input  wire rv_core_pkg::word_t mem_rdata_i,

    output rv_core_pkg::pc_t    pc_o,
    output rv_core_pkg::word_t  ir_o
);
    import rv_core_pkg::*;

    pc_t pc_q;
    pc_t pc_next;

    assign pc_next = redirect_i ? target_i : pc_q + 32'd4;

    // the new PC is visible in the cycle it is taken, so the fetch
    // address can go out on the same edge
    assign pc_o = fetch_next_i ? pc_next : pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (fetch_init_i) begin
            pc_q <= start_addr_i;
        end else if (fetch_next_i) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load_i) begin
            ir_o <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
// instruction decode
// splits the IR into register indices, builds the immediate and
// maps opcode/funct fields to an instruction class and ALU operation

`default_nettype none
`timescale 1ns/1ns

module rv_decode (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         decode_en_i,

    input  wire rv_core_pkg::word_t     ir_i,
    input  wire rv_core_pkg::pc_t       pc_i,

    output rv_core_pkg::reg_addr_t      rs1_o,
    output rv_core_pkg::reg_addr_t      rs2_o,
    output rv_core_pkg::reg_addr_t      rd_o,
    output rv_core_pkg::word_t          imm_o,
    output rv_core_pkg::pc_t            pc_o,
    output rv_core_pkg::instr_class_t   cls_o,
    output rv_core_pkg::alu_op_t        alu_op_o,
    output logic                        branch_ne_o
);
    import rv_core_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    word_t        imm_i_type;
    word_t        imm;
    instr_class_t cls;
    alu_op_t      alu_op;
    logic         branch_ne;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    // register file reads in the decode cycle
    assign rs1_o = ir_i[19:15];
    assign rs2_o = ir_i[24:20];

    assign imm_i_type = {{20{ir_i[31]}}, ir_i[31:20]};

    always_comb begin
        cls       = CLS_HALT;
        alu_op    = ALU_ADD;
        imm       = imm_i_type;
        branch_ne = 1'b0;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                cls = (opcode == OPC_OP) ? CLS_ALU_REG : CLS_ALU_IMM;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: cls = CLS_HALT;
                endcase
                if (opcode == OPC_OP) begin
                    if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                        alu_op = ALU_SUB;
                    end else if (funct7 != 7'b0) begin
                        cls = CLS_HALT;
                    end
                end
            end
            OPC_LUI: begin
                cls    = CLS_LUI;
                alu_op = ALU_PASS_B;
                imm    = {ir_i[31:12], 12'b0};
            end
            OPC_JAL: begin
                cls = CLS_JAL;
                imm = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                // BEQ and BNE only
                cls       = (funct3[2:1] == 2'b00) ? CLS_BRANCH : CLS_HALT;
                branch_ne = funct3[0];
                imm = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
            end
            OPC_LOAD: begin
                cls = (funct3 == 3'b010) ? CLS_LOAD : CLS_HALT;
            end
            OPC_STORE: begin
                cls = (funct3 == 3'b010) ? CLS_STORE : CLS_HALT;
                imm = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
            end
            default: cls = CLS_HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cls_o       <= CLS_HALT;
            alu_op_o    <= ALU_ADD;
            branch_ne_o <= 1'b0;
        end else if (decode_en_i) begin
            cls_o       <= cls;
            alu_op_o    <= alu_op;
            branch_ne_o <= branch_ne;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en_i) begin
            rd_o  <= ir_i[11:7];
            imm_o <= imm;
            pc_o  <= pc_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_reg_file.sv
// integer register file
// 32 entries, two registered read ports and one write port;
// x0 is never written and always reads zero

`default_nettype none
`timescale 1ns/1ns

module rv_reg_file (
    input  wire                         clk,
    input  wire                         rst_n_i,

    input  wire                         read_en_i,
    input  wire rv_core_pkg::reg_addr_t rs1_addr_i,
    input  wire rv_core_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t          rs1_data_o,
    output rv_core_pkg::word_t          rs2_data_o,

    input  wire                         write_en_i,
    input  wire rv_core_pkg::reg_addr_t write_addr_i,
    input  wire rv_core_pkg::word_t     write_data_i
);
    import rv_core_pkg::*;

    word_t regs [2**REG_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_BITS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en_i && write_addr_i != '0) begin
            regs[write_addr_i] <= write_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en_i) begin
            rs1_data_o <= regs[rs1_addr_i];
            rs2_data_o <= regs[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
// execution unit
// ALU, branch compare, jump target, link value and load/store
// word address; every result is registered on exe_en_i

`default_nettype none
`timescale 1ns/1ns

module rv_execute (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             exe_en_i,

    input  wire rv_core_pkg::instr_class_t  cls_i,
    input  wire rv_core_pkg::alu_op_t       alu_op_i,
    input  wire                             branch_ne_i,
    input  wire rv_core_pkg::word_t         rs1_i,
    input  wire rv_core_pkg::word_t         rs2_i,
    input  wire rv_core_pkg::word_t         imm_i,
    input  wire rv_core_pkg::pc_t           pc_i,
    input  wire rv_core_pkg::reg_addr_t     rd_i,

    output rv_core_pkg::word_t              result_o,
    output rv_core_pkg::reg_addr_t          rd_o,
    output logic                            write_rd_o,
    output logic                            redirect_o,
    output rv_core_pkg::pc_t                target_o,
    output rv_core_pkg::mem_addr_t          mem_addr_o,
    output rv_core_pkg::word_t              store_data_o
);
    import rv_core_pkg::*;

    word_t op_b;
    word_t alu_out;
    word_t eff_addr;
    logic  taken;
    logic  writes_rd;

    assign op_b = (cls_i == CLS_ALU_REG) ? rs2_i : imm_i;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_out = rs1_i - op_b;
            ALU_XOR:    alu_out = rs1_i ^ op_b;
            ALU_OR:     alu_out = rs1_i | op_b;
            ALU_AND:    alu_out = rs1_i & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = rs1_i + op_b;
        endcase
    end

    // equality, flipped for BNE
    assign taken    = (rs1_i == rs2_i) ^ branch_ne_i;
    assign eff_addr = rs1_i + imm_i;

    assign writes_rd = (cls_i inside {CLS_ALU_IMM, CLS_ALU_REG, CLS_LUI, CLS_JAL})
                       && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            write_rd_o <= 1'b0;
            redirect_o <= 1'b0;
        end else if (exe_en_i) begin
            write_rd_o <= writes_rd;
            redirect_o <= (cls_i == CLS_JAL) || (cls_i == CLS_BRANCH && taken);
        end
    end

    always_ff @(posedge clk) begin
        if (exe_en_i) begin
            // JAL links to the next instruction
            result_o     <= (cls_i == CLS_JAL) ? pc_i + 32'd4 : alu_out;
            rd_o         <= rd_i;
            target_o     <= pc_i + imm_i;
            mem_addr_o   <= eff_addr[MEM_ADDR_BITS+1:2];
            store_data_o <= rs2_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_controller.sv
// core controller
// sequences fetch, decode, execute and memory access one instruction
// at a time, steers the memory port and the register write-back

`default_nettype none
`timescale 1ns/1ns

module rv_controller (
    input  wire                             clk,
    input  wire                             rst_n_i,

    input  wire                             start_i,
    input  wire rv_core_pkg::pc_t           start_addr_i,
    input  wire rv_core_pkg::instr_class_t  cls_i,

    input  wire rv_core_pkg::pc_t           pc_i,
    input  wire rv_core_pkg::mem_addr_t     exe_mem_addr_i,
    input  wire rv_core_pkg::word_t         store_data_i,
    input  wire rv_core_pkg::word_t         result_i,
    input  wire rv_core_pkg::reg_addr_t     rd_i,
    input  wire                             write_rd_i,
    input  wire rv_core_pkg::word_t         mem_rdata_i,

    output logic                            fetch_init_o,
    output logic                            fetch_next_o,
    output logic                            ir_load_o,
    output logic                            decode_en_o,
    output logic                            exe_en_o,

    output logic                            reg_we_o,
    output rv_core_pkg::reg_addr_t          reg_waddr_o,
    output rv_core_pkg::word_t              reg_wdata_o,

    output rv_core_pkg::mem_addr_t          mem_addr_o,
    output logic                            mem_we_o,
    output rv_core_pkg::word_t              mem_wdata_o,
    output logic                            paused_o
);
    import rv_core_pkg::*;

    typedef enum logic [2:0] {
        IDLE, FETCH_ADDR, FETCH_DATA, DECODE, EXECUTE, MEM, LOAD_WB, HALTED
    } state_t;

    state_t state;
    state_t state_next;
    logic   retire_q;

    // --------------------
    // state machine
    always_comb begin
        state_next = state;
        case (state)
            IDLE, HALTED: if (start_i) state_next = FETCH_ADDR;
            FETCH_ADDR:   state_next = FETCH_DATA;
            FETCH_DATA:   state_next = DECODE;
            DECODE:       state_next = EXECUTE;
            EXECUTE: begin
                // class is valid here, one cycle after decode
                if (cls_i == CLS_HALT) begin
                    state_next = HALTED;
                end else if (cls_i == CLS_LOAD || cls_i == CLS_STORE) begin
                    state_next = MEM;
                end else begin
                    state_next = FETCH_ADDR;
                end
            end
            MEM:     state_next = (cls_i == CLS_LOAD) ? LOAD_WB : FETCH_ADDR;
            default: state_next = FETCH_ADDR;
        endcase
    end

    // retire_q marks a fetch that follows a finished instruction
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            retire_q <= 1'b0;
        end else begin
            state    <= state_next;
            retire_q <= (state_next == FETCH_ADDR) && !paused_o;
        end
    end

    // --------------------
    // strobes
    assign paused_o     = (state == IDLE) || (state == HALTED);
    assign fetch_init_o = paused_o && start_i;
    assign fetch_next_o = (state == FETCH_ADDR) && retire_q;
    assign ir_load_o    = (state == FETCH_DATA);
    assign decode_en_o  = (state == DECODE);
    assign exe_en_o     = (state == EXECUTE);

    // ALU/LUI/JAL results land together with the PC update
    assign reg_we_o    = (fetch_next_o && write_rd_i) || ((state == LOAD_WB) && rd_i != '0);
    assign reg_waddr_o = rd_i;
    assign reg_wdata_o = (state == LOAD_WB) ? mem_rdata_i : result_i;

    // --------------------
    // memory port
    always_comb begin
        if (state == MEM) begin
            mem_addr_o = exe_mem_addr_i;
        end else if (paused_o) begin
            // park on the start address while waiting
            mem_addr_o = start_addr_i[MEM_ADDR_BITS+1:2];
        end else begin
            mem_addr_o = pc_i[MEM_ADDR_BITS+1:2];
        end
    end

    assign mem_we_o    = (state == MEM) && (cls_i == CLS_STORE);
    assign mem_wdata_o = store_data_i;

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
// rv32i subset core, top level
// connects fetch, decode, register file, execute and the controller
// to a single-port word memory and the PC/IR peek outputs

`default_nettype none
`timescale 1ns/1ns

module rv_core (
    input  wire                         clk,
    input  wire                         rst_n_i,

    input  wire                         start_i,
    input  wire rv_core_pkg::pc_t       start_addr_i,

    output rv_core_pkg::mem_addr_t      mem_addr_o,
    output logic                        mem_we_o,
    output rv_core_pkg::word_t          mem_wdata_o,
    input  wire rv_core_pkg::word_t     mem_rdata_i,

    output rv_core_pkg::pc_t            peek_pc_o,
    output rv_core_pkg::word_t          peek_ir_o,
    output logic                        paused_o
);
    import rv_core_pkg::*;

    logic         fetch_init, fetch_next, ir_load, decode_en, exe_en;
    pc_t          fetch_pc;
    word_t        fetch_ir;

    reg_addr_t    dec_rs1, dec_rs2, dec_rd;
    word_t        dec_imm;
    pc_t          dec_pc;
    instr_class_t dec_cls;
    alu_op_t      dec_alu_op;
    logic         dec_branch_ne;
    word_t        rs1_data, rs2_data;

    word_t        exe_result, exe_store_data;
    reg_addr_t    exe_rd;
    logic         exe_write_rd, exe_redirect;
    pc_t          exe_target;
    mem_addr_t    exe_mem_addr;

    logic         reg_we;
    reg_addr_t    reg_waddr;
    word_t        reg_wdata;

    assign peek_pc_o = fetch_pc;
    assign peek_ir_o = fetch_ir;

    rv_fetch u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_init_i (fetch_init),
        .start_addr_i (start_addr_i),
        .fetch_next_i (fetch_next),
        .redirect_i   (exe_redirect),
        .target_i     (exe_target),
        .ir_load_i    (ir_load),
        .mem_rdata_i  (mem_rdata_i),
        .pc_o         (fetch_pc),
        .ir_o         (fetch_ir)
    );

    rv_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .decode_en_i (decode_en),
        .ir_i        (fetch_ir),
        .pc_i        (fetch_pc),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .rd_o        (dec_rd),
        .imm_o       (dec_imm),
        .pc_o        (dec_pc),
        .cls_o       (dec_cls),
        .alu_op_o    (dec_alu_op),
        .branch_ne_o (dec_branch_ne)
    );

    rv_reg_file u_reg_file (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .read_en_i    (decode_en),
        .rs1_addr_i   (dec_rs1),
        .rs2_addr_i   (dec_rs2),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .write_en_i   (reg_we),
        .write_addr_i (reg_waddr),
        .write_data_i (reg_wdata)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .exe_en_i     (exe_en),
        .cls_i        (dec_cls),
        .alu_op_i     (dec_alu_op),
        .branch_ne_i  (dec_branch_ne),
        .rs1_i        (rs1_data),
        .rs2_i        (rs2_data),
        .imm_i        (dec_imm),
        .pc_i         (dec_pc),
        .rd_i         (dec_rd),
        .result_o     (exe_result),
        .rd_o         (exe_rd),
        .write_rd_o   (exe_write_rd),
        .redirect_o   (exe_redirect),
        .target_o     (exe_target),
        .mem_addr_o   (exe_mem_addr),
        .store_data_o (exe_store_data)
    );

    rv_controller u_controller (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .start_addr_i   (start_addr_i),
        .cls_i          (dec_cls),
        .pc_i           (fetch_pc),
        .exe_mem_addr_i (exe_mem_addr),
        .store_data_i   (exe_store_data),
        .result_i       (exe_result),
        .rd_i           (exe_rd),
        .write_rd_i     (exe_write_rd),
        .mem_rdata_i    (mem_rdata_i),
        .fetch_init_o   (fetch_init),
        .fetch_next_o   (fetch_next),
        .ir_load_o      (ir_load),
        .decode_en_o    (decode_en),
        .exe_en_o       (exe_en),
        .reg_we_o       (reg_we),
        .reg_waddr_o    (reg_waddr),
        .reg_wdata_o    (reg_wdata),
        .mem_addr_o     (mem_addr_o),
        .mem_we_o       (mem_we_o),
        .mem_wdata_o    (mem_wdata_o),
        .paused_o       (paused_o)
    );

endmodule

`default_nettype wire

// File: tests/rv_core_sva.sv
// memory write and pause assertions for the core top level
// bound into rv_core

`default_nettype none
`timescale 1ns/1ns

module rv_core_sva (
    input wire clk,
    input wire rst_n_i,
    input wire mem_we_o,
    input wire paused_o
);
    // read back by the testbench at the end of the run
    int assert_fails = 0;

    // a parked core never stores
    assert property (@(posedge clk) disable iff (!rst_n_i) paused_o |-> !mem_we_o)
        else begin
            assert_fails++;
            $error("mem_we_o high while paused_o is high");
        end

    // one store lasts a single MEM cycle
    assert property (@(posedge clk) disable iff (!rst_n_i) mem_we_o |=> !mem_we_o)
        else begin
            assert_fails++;
            $error("mem_we_o high in two consecutive cycles");
        end

    assert property (@(posedge clk) $rose(rst_n_i) |-> paused_o)
        else begin
            assert_fails++;
            $error("paused_o low in the first cycle after reset");
        end

endmodule

bind rv_core rv_core_sva u_sva (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .mem_we_o (mem_we_o),
    .paused_o (paused_o)
);

`default_nettype wire

// File: tests/rv_core_tb.sv
// testbench for the rv32i subset core
// word memory model with one-cycle read latency, program loader
// and directed tests for ALU, LUI, load/store, branches, JAL and halt

`default_nettype none
`timescale 1ns/1ns

module rv_core_tb;
    import rv_core_pkg::*;

    // six programs under 30 instructions, at most 6 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam word_t ECALL = 32'h0000_0073;

    logic      clk;
    logic      rst_n_i;
    logic      start_i;
    pc_t       start_addr_i;
    mem_addr_t mem_addr;
    logic      mem_we;
    word_t     mem_wdata;
    word_t     mem_rdata;
    pc_t       peek_pc;
    word_t     peek_ir;
    logic      paused;

    word_t  mem [2**MEM_ADDR_BITS];
    word_t  prog [$];
    integer seed;
    int     cycle_count = 0;

    rv_core dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .start_addr_i (start_addr_i),
        .mem_addr_o   (mem_addr),
        .mem_we_o     (mem_we),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .peek_pc_o    (peek_pc),
        .peek_ir_o    (peek_ir),
        .paused_o     (paused)
    );

    always #10 clk = ~clk;

    // --------------------
    // memory model
    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the core never paused within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // --------------------
    // instruction encoding, RV32I formats
    function automatic word_t op_imm(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t lui(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t jal(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // background pattern, unique per word address
    function automatic word_t fill_value(input int idx);
        return 32'hC0DE_0000 ^ word_t'(idx);
    endfunction

    // --------------------
    // checks
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s = %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s = %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s = %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_mem_word(input int idx, input word_t exp);
        check_word($sformatf("mem[%0d]", idx), mem[idx], exp);
    endtask

    // --------------------
    // program loading and running
    task automatic load_program(input pc_t base);
        @(posedge clk);
        foreach (prog[i]) begin
            mem[int'(base[11:2]) + i] <= prog[i];
        end
        prog.delete();
    endtask

    // pulse start, then wait for the core to pause again
    task automatic run_program(input pc_t start_addr);
        @(posedge clk);
        start_i      <= 1'b1;
        start_addr_i <= start_addr;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        check_bit("paused_o", paused, 1'b0);
        while (!paused) begin
            @(negedge clk);
        end
    endtask

    // --------------------
    // directed tests
    task automatic reset_test();
        repeat (5) begin
            @(negedge clk);
            check_bit("paused_o", paused, 1'b1);
            check_bit("mem_we_o", mem_we, 1'b0);
        end
    endtask

    task automatic alu_test();
        logic [11:0] imm_a, imm_b, imm_c, imm_d, imm_e;
        word_t       x1, x5;
        word_t       expected [11];
        imm_a = 12'($random(seed));
        imm_b = 12'($random(seed));
        imm_c = 12'($random(seed));
        imm_d = 12'($random(seed));
        imm_e = 12'($random(seed));
        x1 = sext12(imm_a);
        x5 = sext12(imm_e);
        expected = '{x1, x1 ^ sext12(imm_b), x1 | sext12(imm_c), x1 & sext12(imm_d), x5,
                     x1 + x5, x1 - x5, x1 ^ x5, x1 | x5, x1 & x5, 32'h0};
        prog.push_back(op_imm(3'b000, 5'd1, 5'd0, imm_a));
        prog.push_back(op_imm(3'b100, 5'd2, 5'd1, imm_b));
        prog.push_back(op_imm(3'b110, 5'd3, 5'd1, imm_c));
        prog.push_back(op_imm(3'b111, 5'd4, 5'd1, imm_d));
        prog.push_back(op_imm(3'b000, 5'd5, 5'd0, imm_e));
        prog.push_back(op_reg(7'b0000000, 3'b000, 5'd6, 5'd1, 5'd5));
        prog.push_back(op_reg(7'b0100000, 3'b000, 5'd7, 5'd1, 5'd5));
        prog.push_back(op_reg(7'b0000000, 3'b100, 5'd8, 5'd1, 5'd5));
        prog.push_back(op_reg(7'b0000000, 3'b110, 5'd9, 5'd1, 5'd5));
        prog.push_back(op_reg(7'b0000000, 3'b111, 5'd10, 5'd1, 5'd5));
        // attempted write to x0
        prog.push_back(op_imm(3'b000, 5'd0, 5'd1, 12'h7ff));
        for (int k = 0; k < 10; k++) begin
            prog.push_back(store_word(reg_addr_t'(k + 1), 5'd0, 12'(12'h400 + 4 * k)));
        end
        prog.push_back(store_word(5'd0, 5'd0, 12'h428));
        prog.push_back(ECALL);
        load_program(32'h0);
        run_program(32'h0);
        for (int k = 0; k < 11; k++) begin
            check_mem_word(256 + k, expected[k]);
        end
        check_pc("peek_pc_o", peek_pc, 32'h58);
    endtask

    task automatic lui_load_store_test();
        prog.push_back(lui(5'd11, 20'hABCDE));
        prog.push_back(store_word(5'd11, 5'd0, 12'h500));
        prog.push_back(load_word(5'd12, 5'd0, 12'h500));
        prog.push_back(store_word(5'd12, 5'd0, 12'h504));
        prog.push_back(ECALL);
        load_program(32'h100);
        run_program(32'h100);
        check_mem_word(320, 32'hABCD_E000);
        check_mem_word(321, 32'hABCD_E000);
        check_pc("peek_pc_o", peek_pc, 32'h110);
    endtask

    task automatic branch_test();
        prog.push_back(op_imm(3'b000, 5'd13, 5'd0, 12'd5));
        prog.push_back(op_imm(3'b000, 5'd14, 5'd0, 12'd5));
        prog.push_back(op_imm(3'b000, 5'd15, 5'd0, 12'd7));
        // beq taken, skips the marker store
        prog.push_back(branch(3'b000, 5'd13, 5'd14, 13'd8));
        prog.push_back(store_word(5'd15, 5'd0, 12'h600));
        prog.push_back(store_word(5'd13, 5'd0, 12'h604));
        // beq not taken
        prog.push_back(branch(3'b000, 5'd13, 5'd15, 13'd8));
        prog.push_back(store_word(5'd15, 5'd0, 12'h608));
        // bne taken
        prog.push_back(branch(3'b001, 5'd13, 5'd15, 13'd8));
        prog.push_back(store_word(5'd15, 5'd0, 12'h60C));
        prog.push_back(store_word(5'd14, 5'd0, 12'h610));
        // bne not taken
        prog.push_back(branch(3'b001, 5'd13, 5'd14, 13'd8));
        prog.push_back(store_word(5'd15, 5'd0, 12'h614));
        prog.push_back(ECALL);
        load_program(32'h200);
        run_program(32'h200);
        check_mem_word(384, fill_value(384));
        check_mem_word(385, 32'd5);
        check_mem_word(386, 32'd7);
        check_mem_word(387, fill_value(387));
        check_mem_word(388, 32'd5);
        check_mem_word(389, 32'd7);
        check_pc("peek_pc_o", peek_pc, 32'h234);
    endtask

    task automatic jal_test();
        prog.push_back(jal(5'd16, 21'd12));
        prog.push_back(op_imm(3'b000, 5'd17, 5'd0, 12'h055));
        prog.push_back(store_word(5'd17, 5'd0, 12'h700));
        prog.push_back(store_word(5'd16, 5'd0, 12'h704));
        prog.push_back(ECALL);
        load_program(32'h300);
        run_program(32'h300);
        check_mem_word(448, fill_value(448));
        check_mem_word(449, 32'h304);
        check_pc("peek_pc_o", peek_pc, 32'h310);
    endtask

    task automatic halt_resume_test();
        prog.push_back(op_imm(3'b000, 5'd18, 5'd0, 12'd42));
        prog.push_back(ECALL);
        load_program(32'h380);
        run_program(32'h380);
        // the halt holds until the next start pulse
        repeat (3) @(negedge clk);
        check_bit("paused_o", paused, 1'b1);
        check_pc("peek_pc_o", peek_pc, 32'h384);
        check_word("peek_ir_o", peek_ir, ECALL);
        // resume somewhere else, x18 must survive the halt
        prog.push_back(store_word(5'd18, 5'd0, 12'h708));
        prog.push_back(ECALL);
        load_program(32'h3A0);
        run_program(32'h3A0);
        check_mem_word(450, 32'd42);
        check_pc("peek_pc_o", peek_pc, 32'h3A4);
    endtask

    // --------------------
    // main sequence
    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        start_i      = 1'b0;
        start_addr_i = '0;
        mem_rdata    = '0;
        seed         = 32'h684335a3;
        for (int i = 0; i < 2**MEM_ADDR_BITS; i++) begin
            mem[i] = fill_value(i);
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        reset_test();
        alu_test();
        lui_load_store_test();
        branch_test();
        jal_test();
        halt_resume_test();

        if (dut.u_sva.assert_fails != 0) begin
            $display("%0d assertion failures during the run", dut.u_sva.assert_fails);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_reg_file.sv
hdl/rv_execute.sv
hdl/rv_controller.sv
hdl/rv_core.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv
